// File: osd_defines.svh
/*
 * overlay geometry, fixed window position, tint colour
 * and bitmap buffer depth
 */
`ifndef OSD_DEFINES_SVH
`define OSD_DEFINES_SVH

// window size in pixels and lines
`define OSD_WIDTH 256
`define OSD_HEIGHT 128

// top left corner of the window
`define OSD_X_OFFSET 8
`define OSD_Y_OFFSET 4

// tint bits for red green blue from msb
`define OSD_COLOR 3'd4

`define OSD_BUF_DEPTH 4096

// de-low gap over this many line widths starts a frame
`define OSD_BLANK_RATIO 4

`endif

// File: osdHostPkg.sv
/*
 * host port types for the command word, bitmap address and byte,
 * receiver states and the buffer write bundle
 */
package osdHostPkg;

    typedef logic [15:0] hostWord_t;
    typedef logic [11:0] bufAddr_t;
    typedef logic [7:0]  bufByte_t;

    // command receiver
    typedef enum logic [1:0] {
        IDLE,
        ENABLE_CMD,
        WRITE_CMD
    } rxState_t;

    typedef struct packed {
        logic     valid;
        bufAddr_t addr;
        bufByte_t data;
    } bufWrite_t;

endpackage

// File: osdVideoPkg.sv
/*
 * video pipeline types for the rgb pixel, raster counters
 * and the tag that travels with each pixel
 */
package osdVideoPkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef logic [11:0] pixCount_t;
    typedef logic [10:0] lineCount_t;
    typedef logic [2:0]  bitIdx_t;

    // per pixel info from the tracker to the blender
    typedef struct packed {
        logic    de;
        logic    inWindow;
        bitIdx_t bitIdx;
        rgb_t    rgb;
    } rasterTag_t;

endpackage

// File: osdCommandRx.sv
/*
 * host command receiver with strobe edge detect,
 * enable flag and bitmap buffer writes
 */
`timescale 1ns/1ns

module osdCommandRx (
    input  logic                  clk_video,
    input  logic                  rst,
    input  logic                  ioOsd,
    input  logic                  ioStrobe,
    input  osdHostPkg::hostWord_t ioDin,
    output osdHostPkg::bufWrite_t bufWrite,
    output logic                  osdEnable
);

    osdHostPkg::rxState_t state;
    osdHostPkg::bufAddr_t wrAddr;
    logic                 strobeD;
    logic                 strobeRise;
    logic                 cmdTaken;
    logic                 newEnable;

    assign strobeRise = ioStrobe & ~strobeD;

    always_ff @(posedge clk_video) begin
        if (rst) begin
            state          <= osdHostPkg::IDLE;
            strobeD        <= 1'b0;
            cmdTaken       <= 1'b0;
            newEnable      <= 1'b0;
            osdEnable      <= 1'b0;
            bufWrite.valid <= 1'b0;
        end else begin
            strobeD        <= ioStrobe;
            bufWrite.valid <= 1'b0;

            if (!ioOsd) begin
                // enable takes effect as the select drops
                if (state == osdHostPkg::ENABLE_CMD) begin
                    osdEnable <= newEnable;
                end
                state    <= osdHostPkg::IDLE;
                cmdTaken <= 1'b0;
            end else if (strobeRise) begin
                if (!cmdTaken) begin
                    // command code sits in the low byte
                    cmdTaken <= 1'b1;
                    case (ioDin[7:4])
                        4'h4: begin
                            state     <= osdHostPkg::ENABLE_CMD;
                            newEnable <= ioDin[0];
                        end
                        4'h2: begin
                            state <= osdHostPkg::WRITE_CMD;
                        end
                        default: begin
                            state <= osdHostPkg::IDLE;
                        end
                    endcase
                end else if (state == osdHostPkg::WRITE_CMD) begin
                    bufWrite.valid <= 1'b1;
                end
            end
        end

        // address steps once per data word
        if (ioOsd && strobeRise) begin
            if (!cmdTaken) begin
                wrAddr <= {ioDin[3:0], 8'h00};
            end else begin
                wrAddr <= wrAddr + 1'b1;
            end
        end
        bufWrite.addr <= wrAddr;
        bufWrite.data <= ioDin[7:0];
    end

endmodule

// File: osdRasterTracker.sv
/*
 * frame and line detection from de, window test
 * and bitmap read address, tag delayed to match the ram
 */
`timescale 1ns/1ns
`include "osd_defines.svh"

module osdRasterTracker (
    input  logic                    clk_video,
    input  logic                    rst,
    input  osdVideoPkg::rgb_t       din,
    input  logic                    deIn,
    input  logic                    osdEnable,
    output osdHostPkg::bufAddr_t    rdAddr,
    output osdVideoPkg::rasterTag_t tag
);

    osdVideoPkg::pixCount_t  colCnt;
    osdVideoPkg::pixCount_t  activeWidth;
    osdVideoPkg::pixCount_t  gapCnt;
    osdVideoPkg::pixCount_t  curCol;
    osdVideoPkg::pixCount_t  winX;
    osdVideoPkg::lineCount_t lineCnt;
    osdVideoPkg::lineCount_t curLine;
    osdVideoPkg::lineCount_t winY;
    osdVideoPkg::rasterTag_t tagS1;
    logic                    deD;
    logic                    deRise;
    logic                    frameStart;
    logic                    frameEn;
    logic                    curEn;
    logic                    inWin;

    assign deRise     = deIn & ~deD;
    assign frameStart = deRise && (gapCnt > `OSD_BLANK_RATIO * activeWidth);

    // position of the pixel on the input right now
    assign curCol  = deRise ? '0 : colCnt;
    assign curLine = frameStart ? '0 : (deRise ? lineCnt + 1'b1 : lineCnt);
    assign curEn   = frameStart ? osdEnable : frameEn;

    assign winX  = curCol - osdVideoPkg::pixCount_t'(`OSD_X_OFFSET);
    assign winY  = curLine - osdVideoPkg::lineCount_t'(`OSD_Y_OFFSET);
    assign inWin = curEn && deIn
        && (curLine >= `OSD_Y_OFFSET) && (curLine < `OSD_Y_OFFSET + `OSD_HEIGHT)
        && (curCol >= `OSD_X_OFFSET) && (curCol < `OSD_X_OFFSET + `OSD_WIDTH);

    always_ff @(posedge clk_video) begin
        if (rst) begin
            deD            <= 1'b0;
            colCnt         <= '0;
            activeWidth    <= '0;
            gapCnt         <= '0;
            lineCnt        <= '1;
            frameEn        <= 1'b0;
            tagS1.de       <= 1'b0;
            tagS1.inWindow <= 1'b0;
            tag.de         <= 1'b0;
            tag.inWindow   <= 1'b0;
        end else begin
            deD     <= deIn;
            lineCnt <= curLine;
            frameEn <= curEn;
            if (deIn) begin
                colCnt <= curCol + 1'b1;
                gapCnt <= '0;
            end else if (~&gapCnt) begin
                gapCnt <= gapCnt + 1'b1;
            end
            if (deD && !deIn) begin
                activeWidth <= colCnt;
            end
            tagS1.de       <= deIn;
            tagS1.inWindow <= inWin;
            tag.de         <= tagS1.de;
            tag.inWindow   <= tagS1.inWindow;
        end

        // byte row from y, column from x
        rdAddr       <= {winY[6:3], winX[7:0]};
        tagS1.bitIdx <= winY[2:0];
        tagS1.rgb    <= din;
        tag.bitIdx   <= tagS1.bitIdx;
        tag.rgb      <= tagS1.rgb;
    end

endmodule

// File: osdBitmapRam.sv
/*
 * bitmap byte memory, host write port and
 * registered video read port
 */
`timescale 1ns/1ns
`include "osd_defines.svh"

module osdBitmapRam (
    input  logic                  clk_video,
    input  osdHostPkg::bufWrite_t bufWrite,
    input  osdHostPkg::bufAddr_t  rdAddr,
    output osdHostPkg::bufByte_t  rdData
);

    osdHostPkg::bufByte_t mem [`OSD_BUF_DEPTH];

    // start from a blank bitmap
    initial begin
        for (int i = 0; i < `OSD_BUF_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk_video) begin
        if (bufWrite.valid) begin
            mem[bufWrite.addr] <= bufWrite.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk_video) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: osdBlender.sv
/*
 * bitmap bit select and colour blend,
 * output pixel and de registers
 */
`timescale 1ns/1ns
`include "osd_defines.svh"

module osdBlender (
    input  logic                    clk_video,
    input  logic                    rst,
    input  osdVideoPkg::rasterTag_t tag,
    input  osdHostPkg::bufByte_t    rdData,
    output osdVideoPkg::rgb_t       dout,
    output logic                    deOut
);

    localparam logic [2:0] tintColor = `OSD_COLOR;

    osdVideoPkg::rgb_t osdPix;
    logic              pixBit;

    // lit bit twice, tint twice, then top half of the video
    function automatic logic [7:0] blendChan(
        input logic [7:0] chan,
        input logic       lit,
        input logic       tintBit
    );
        return {lit, lit, tintBit, tintBit, chan[7:4]};
    endfunction

    assign pixBit   = rdData[tag.bitIdx];
    assign osdPix.r = blendChan(tag.rgb.r, pixBit, tintColor[2]);
    assign osdPix.g = blendChan(tag.rgb.g, pixBit, tintColor[1]);
    assign osdPix.b = blendChan(tag.rgb.b, pixBit, tintColor[0]);

    always_ff @(posedge clk_video) begin
        if (rst) begin
            dout  <= '0;
            deOut <= 1'b0;
        end else begin
            dout  <= tag.inWindow ? osdPix : tag.rgb;
            deOut <= tag.de;
        end
    end

endmodule

// File: osdTop.sv
/*
 * overlay top level with command receiver, raster tracker,
 * bitmap ram and blender
 */
`timescale 1ns/1ns

module osdTop (
    input  logic                  clk_video,
    input  logic                  rst,
    input  logic                  ioOsd,
    input  logic                  ioStrobe,
    input  osdHostPkg::hostWord_t ioDin,
    input  osdVideoPkg::rgb_t     din,
    input  logic                  deIn,
    output osdVideoPkg::rgb_t     dout,
    output logic                  deOut,
    output logic                  osdStatus
);

    osdHostPkg::bufWrite_t   bufWrite;
    osdHostPkg::bufAddr_t    rdAddr;
    osdHostPkg::bufByte_t    rdData;
    osdVideoPkg::rasterTag_t tag;
    logic                    osdEnable;

    assign osdStatus = osdEnable;

    osdCommandRx commandRx (
        .clk_video (clk_video),
        .rst       (rst),
        .ioOsd     (ioOsd),
        .ioStrobe  (ioStrobe),
        .ioDin     (ioDin),
        .bufWrite  (bufWrite),
        .osdEnable (osdEnable)
    );

    // stage 1
    osdRasterTracker rasterTracker (
        .clk_video (clk_video),
        .rst       (rst),
        .din       (din),
        .deIn      (deIn),
        .osdEnable (osdEnable),
        .rdAddr    (rdAddr),
        .tag       (tag)
    );

    // stage 2
    osdBitmapRam bitmapRam (
        .clk_video (clk_video),
        .bufWrite  (bufWrite),
        .rdAddr    (rdAddr),
        .rdData    (rdData)
    );

    // stage 3
    osdBlender blender (
        .clk_video (clk_video),
        .rst       (rst),
        .tag       (tag),
        .rdData    (rdData),
        .dout      (dout),
        .deOut     (deOut)
    );

endmodule

// File: tbOsd.sv
/*
 * overlay testbench with clock and reset, host command transfers,
 * frame generator, pixel checks against a bitmap model and a watchdog
 */
`timescale 1ns/1ns
`include "osd_defines.svh"

module tbOsd;

    localparam int frameLines  = 140;
    localparam int activeCols  = 280;
    localparam int blankCols   = 40;
    localparam int frameGap    = 2000;
    localparam int frameCycles = frameGap + frameLines * (activeCols + blankCols);

    // one driven pixel and the value expected for it
    typedef struct packed {
        logic              de;
        logic [10:0]       line;
        logic [11:0]       col;
        osdVideoPkg::rgb_t din;
        osdVideoPkg::rgb_t want;
    } pixRecord_t;

    logic                  clk_video = 1'b0;
    logic                  rst;
    logic                  ioOsd;
    logic                  ioStrobe;
    osdHostPkg::hostWord_t ioDin;
    osdVideoPkg::rgb_t     din;
    logic                  deIn;
    osdVideoPkg::rgb_t     dout;
    logic                  deOut;
    logic                  osdStatus;

    osdHostPkg::bufByte_t  bitmapModel [`OSD_BUF_DEPTH];
    osdVideoPkg::rgb_t     dinStore [frameLines][activeCols];
    osdVideoPkg::rgb_t     doutStore [frameLines][activeCols];
    pixRecord_t            inFlight [$];
    osdHostPkg::hostWord_t hostWords [$];
    logic                  enModel;
    logic                  frameEnModel;
    int                    videoLine;
    int                    videoCol;
    int                    testErrors;
    int                    totalErrors;
    int                    passCount;
    int                    failCount;
    int                    testNum;
    time                   watchdogLimit;

    always #20 clk_video = ~clk_video;

    osdTop UUT (
        .clk_video (clk_video),
        .rst       (rst),
        .ioOsd     (ioOsd),
        .ioStrobe  (ioStrobe),
        .ioDin     (ioDin),
        .din       (din),
        .deIn      (deIn),
        .dout      (dout),
        .deOut     (deOut),
        .osdStatus (osdStatus)
    );

    task automatic noteMismatch(input string name, input logic [23:0] got,
                                input logic [23:0] want, input int line, input int col);
        testErrors++;
        totalErrors++;
        $display("mismatch %s at line %0d col %0d: got %0h expected %0h",
                 name, line, col, got, want);
    endtask

    task automatic finishTest(input string name);
        testNum++;
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s: passed", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed with %0d errors", testNum, name, testErrors);
        end
        testErrors = 0;
    endtask

    // bright or tinted dark pixel inside the window
    function automatic osdVideoPkg::rgb_t overlayPixel(input osdVideoPkg::rgb_t pix,
                                                       input logic lit);
        logic [2:0]        tint;
        osdVideoPkg::rgb_t res;
        tint  = `OSD_COLOR;
        res.r = {lit, lit, tint[2], tint[2], pix.r[7:4]};
        res.g = {lit, lit, tint[1], tint[1], pix.g[7:4]};
        res.b = {lit, lit, tint[0], tint[0], pix.b[7:4]};
        return res;
    endfunction

    function automatic osdVideoPkg::rgb_t expectedPixel(input logic de, input int line,
                                                        input int col,
                                                        input osdVideoPkg::rgb_t pix);
        int   x;
        int   y;
        logic lit;
        x = col - `OSD_X_OFFSET;
        y = line - `OSD_Y_OFFSET;
        if (!de || !frameEnModel || x < 0 || x >= `OSD_WIDTH || y < 0 || y >= `OSD_HEIGHT) begin
            return pix;
        end
        lit = bitmapModel[(y / 8) * 256 + x][y % 8];
        return overlayPixel(pix, lit);
    endfunction

    task automatic checkOutput(input pixRecord_t rec);
        assert (deOut === rec.de)
            else noteMismatch("deOut", deOut, rec.de, rec.line, rec.col);
        assert (dout === rec.want)
            else noteMismatch("dout", dout, rec.want, rec.line, rec.col);
        if (rec.de) begin
            dinStore[rec.line][rec.col]  = rec.din;
            doutStore[rec.line][rec.col] = dout;
        end
    endtask

    // one clock that drives on the rising edge and checks the pixel from 3 cycles back
    task automatic stepCycle(input logic de, input logic sel, input logic strobe,
                             input osdHostPkg::hostWord_t word);
        logic [31:0]       rnd;
        osdVideoPkg::rgb_t pix;
        pixRecord_t        rec;
        rnd = $urandom;
        pix = rnd[23:0];
        @(posedge clk_video);
        deIn     <= de;
        din      <= pix;
        ioOsd    <= sel;
        ioStrobe <= strobe;
        ioDin    <= word;
        rec.de   = de;
        rec.line = 11'(videoLine);
        rec.col  = 12'(videoCol);
        rec.din  = pix;
        rec.want = expectedPixel(de, videoLine, videoCol, pix);
        inFlight.push_back(rec);
        @(negedge clk_video);
        if (inFlight.size() > 3) begin
            checkOutput(inFlight.pop_front());
        end
    endtask

    // strobe each queued word with two quiet cycles around every edge
    task automatic hostTransfer();
        stepCycle(1'b0, 1'b1, 1'b0, '0);
        foreach (hostWords[i]) begin
            stepCycle(1'b0, 1'b1, 1'b1, hostWords[i]);
            stepCycle(1'b0, 1'b1, 1'b1, hostWords[i]);
            stepCycle(1'b0, 1'b1, 1'b0, hostWords[i]);
            stepCycle(1'b0, 1'b1, 1'b0, hostWords[i]);
        end
        repeat (3) stepCycle(1'b0, 1'b0, 1'b0, '0);
        assert (osdStatus === enModel)
            else noteMismatch("osdStatus", osdStatus, enModel, 0, 0);
    endtask

    task automatic runFrames(input int count);
        int f;
        int ln;
        int c;
        for (f = 0; f < count; f++) begin
            frameEnModel = enModel;
            videoLine    = 0;
            videoCol     = 0;
            repeat (frameGap) stepCycle(1'b0, 1'b0, 1'b0, '0);
            for (ln = 0; ln < frameLines; ln++) begin
                videoLine = ln;
                for (c = 0; c < activeCols; c++) begin
                    videoCol = c;
                    stepCycle(1'b1, 1'b0, 1'b0, '0);
                end
                repeat (blankCols) stepCycle(1'b0, 1'b0, 1'b0, '0);
            end
        end
    endtask

    task automatic countFrames(output int total);
        int               fd;
        int               code;
        int               frames;
        logic [7:0]       kind;
        logic [8*256-1:0] rest;
        total = 0;
        fd = $fopen("osd_trace.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "F") begin
                    code = $fscanf(fd, "%d", frames);
                    total += frames;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runTrace(input int fd);
        int                i;
        int                code;
        int                page;
        int                count;
        int                dataByte;
        int                cmd;
        int                line;
        int                col;
        int                inWin;
        int                bitVal;
        logic [7:0]        kind;
        logic [8*256-1:0]  rest;
        osdVideoPkg::rgb_t want;
        while ($fscanf(fd, " %c", kind) == 1) begin
            hostWords.delete();
            case (kind)
                "#": code = $fgets(rest, fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", page, count);
                    hostWords.push_back({12'h002, page[3:0]});
                    for (i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", dataByte);
                        hostWords.push_back({8'h00, dataByte[7:0]});
                        bitmapModel[page * 256 + i] = dataByte[7:0];
                    end
                    hostTransfer();
                    finishTest($sformatf("write page %0d", page));
                end
                "E", "D": begin
                    enModel = (kind == "E");
                    hostWords.push_back({15'h0020, enModel});
                    hostTransfer();
                    finishTest(enModel ? "enable" : "disable");
                end
                "U": begin
                    code = $fscanf(fd, "%h %h", cmd, dataByte);
                    hostWords.push_back(cmd[15:0]);
                    hostWords.push_back({8'h00, dataByte[7:0]});
                    hostTransfer();
                    finishTest($sformatf("unknown command %0h", cmd));
                end
                "F": begin
                    code = $fscanf(fd, "%d", count);
                    runFrames(count);
                    finishTest($sformatf("run %0d frames", count));
                end
                "P": begin
                    code = $fscanf(fd, "%d %d %d %d", line, col, inWin, bitVal);
                    want = dinStore[line][col];
                    if (inWin != 0) begin
                        want = overlayPixel(want, bitVal[0]);
                    end
                    assert (doutStore[line][col] === want)
                        else noteMismatch("dout", doutStore[line][col], want, line, col);
                    finishTest($sformatf("pixel line %0d col %0d", line, col));
                end
                default: begin
                    code = $fgets(rest, fd);
                    $display("the trace holds an entry of unknown kind %c", kind);
                    testErrors++;
                    totalErrors++;
                    finishTest("trace entry");
                end
            endcase
        end
    endtask

    initial begin
        int          fd;
        int          frameTotal;
        logic [31:0] seedInit;
        rst      <= 1'b1;
        ioOsd    <= 1'b0;
        ioStrobe <= 1'b0;
        ioDin    <= '0;
        din      <= '0;
        deIn     <= 1'b0;
        enModel       = 1'b0;
        frameEnModel  = 1'b0;
        videoLine     = 0;
        videoCol      = 0;
        testErrors    = 0;
        totalErrors   = 0;
        passCount     = 0;
        failCount     = 0;
        testNum       = 0;
        watchdogLimit = 0;
        foreach (bitmapModel[i]) begin
            bitmapModel[i] = '0;
        end
        seedInit = $urandom(32'h3c06cea4);

        repeat (4) @(posedge clk_video);
        rst <= 1'b0;
        @(negedge clk_video);
        assert (deOut === 1'b0) else noteMismatch("deOut", deOut, 0, 0, 0);
        assert (dout === '0) else noteMismatch("dout", dout, 0, 0, 0);
        assert (osdStatus === 1'b0) else noteMismatch("osdStatus", osdStatus, 0, 0, 0);
        finishTest("reset state");

        countFrames(frameTotal);
        fd = $fopen("osd_trace.txt", "r");
        if (fd == 0) begin
            $display("the trace file osd_trace.txt could not be opened");
            failCount++;
        end else begin
            watchdogLimit = time'((frameTotal + 2) * frameCycles * 40);
            runTrace(fd);
            $fclose(fd);
            repeat (4) stepCycle(1'b0, 1'b0, 1'b0, '0);
            finishTest("pipeline drain");
        end

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0 && totalErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // limit from the traced frame count plus two frames of margin
    initial begin
        wait (watchdogLimit != 0);
        #(watchdogLimit);
        $display("timeout: the trace did not finish in %0t", watchdogLimit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: osd_trace.txt
# W page count bytes (hex), E enable, D disable, U command data (hex)
# F frames, P line col inWindow bit (decimal, last frame)
F 1
P 4 8 0 0
P 70 140 0 0
P 139 279 0 0
W 0 4 81 ff 01 80
W 5 3 0f a5 3c
E
F 1
P 4 8 1 1
P 7 8 1 0
P 11 8 1 1
P 9 9 1 1
P 4 10 1 1
P 5 10 1 0
P 11 11 1 1
P 44 8 1 1
P 47 8 1 1
P 48 8 1 0
P 51 8 1 0
P 45 9 1 0
P 51 9 1 1
P 46 10 1 1
P 100 200 1 0
P 131 263 1 0
P 3 8 0 0
P 132 8 0 0
P 20 7 0 0
P 20 264 0 0
U 71 a5
F 1
P 4 8 1 1
P 44 9 1 1
P 12 8 1 0
D
F 1
P 4 8 0 0
P 44 8 0 0

// File: project.f
+incdir+.
osdHostPkg.sv
osdVideoPkg.sv
osdCommandRx.sv
osdRasterTracker.sv
osdBitmapRam.sv
osdBlender.sv
osdTop.sv
tbOsd.sv

// File: Bender.yml
package:
  name: osd_overlay

export_include_dirs:
  - .

sources:
  - osdHostPkg.sv
  - osdVideoPkg.sv
  - osdCommandRx.sv
  - osdRasterTracker.sv
  - osdBitmapRam.sv
  - osdBlender.sv
  - osdTop.sv
  - target: test
    files:
      - tbOsd.sv
